// ==== source/gf_pkg.sv ====
`default_nettype none

package gf_pkg;

	// widest field the alpha helper handles
	localparam int GF_MAX_M = 16;

	// ********************
	// command opcodes
	// ********************
	typedef enum logic [2:0] {
		OP_ADD  = 3'd0,
		OP_MUL  = 3'd1,
		OP_SQR  = 3'd2,
		OP_CUBE = 3'd3,
		OP_DIV  = 3'd4
	} gf_op_e;

	// divide sequencer states
	typedef enum logic [1:0] {
		DIV_IDLE  = 2'd0,
		DIV_LOOP  = 2'd1,
		DIV_FINAL = 2'd2
	} gf_div_state_e;

	// x * alpha in GF(2^m), standard basis
	// poly is the field polynomial without its top term
	function automatic logic [GF_MAX_M-1:0] gf_mul_alpha(
		input logic [GF_MAX_M-1:0] x,
		input logic [GF_MAX_M-1:0] poly,
		input int unsigned m
	);
		logic [GF_MAX_M-1:0] y;
		y = '0;
		for (int i = 1; i < GF_MAX_M; i++) begin
			if (i < m)
				y[i] = x[i-1];
		end
		// top bit wraps around through the polynomial
		if (x[m-1])
			y = y ^ poly;
		return y;
	endfunction

endpackage

`default_nettype wire

// ==== source/gf_cmd_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// decoded command, decode stage to execute stage
interface gf_cmd_if #(
	parameter int M = 8
);
	logic valid;
	gf_pkg::gf_op_e op;
	logic [M-1:0] a;
	logic [M-1:0] b;
	logic div_zero;

	modport src (
		output valid,
		output op,
		output a,
		output b,
		output div_zero
	);

	modport dst (
		input valid,
		input op,
		input a,
		input b,
		input div_zero
	);
endinterface

`default_nettype wire

// ==== source/gf_res_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// computed value, execute stage to result stage
interface gf_res_if #(
	parameter int M = 8
);
	logic valid;
	logic [M-1:0] value;
	logic div_zero;

	modport src (
		output valid,
		output value,
		output div_zero
	);

	modport dst (
		input valid,
		input value,
		input div_zero
	);
endinterface

`default_nettype wire

// ==== source/gf_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module gf_decode #(
	parameter int M = 8
) (
	input  logic clk,
	input  logic reset,
	input  logic cmd_valid,
	input  gf_pkg::gf_op_e cmd_op,
	input  logic [M-1:0] cmd_a,
	input  logic [M-1:0] cmd_b,
	input  logic div_done,
	output logic busy,
	output logic overrun,
	gf_cmd_if.src cmd
);
	gf_pkg::gf_div_state_e window;
	logic accept;

	assign accept = cmd_valid && !busy;
	// busy window of a running divide
	assign busy = (window != gf_pkg::DIV_IDLE);

	// ********************
	// control
	// ********************
	always_ff @(posedge clk) begin
		if (reset) begin
			window <= gf_pkg::DIV_IDLE;
			cmd.valid <= 1'b0;
			overrun <= 1'b0;
		end else begin
			cmd.valid <= accept;
			// dropped commands are flagged one cycle later
			overrun <= cmd_valid && busy;
			if (accept && cmd_op == gf_pkg::OP_DIV)
				window <= gf_pkg::DIV_LOOP;
			else if (div_done)
				window <= gf_pkg::DIV_IDLE;
		end
	end

	// command payload
	always_ff @(posedge clk) begin
		if (accept) begin
			cmd.op <= cmd_op;
			cmd.a <= cmd_a;
			cmd.b <= cmd_b;
			cmd.div_zero <= (cmd_op == gf_pkg::OP_DIV) && (cmd_b == '0);
		end
	end

	// end of divide only inside the busy window
	a_done_in_busy: assert property (@(posedge clk) disable iff (reset)
		div_done |-> busy);
endmodule

`default_nettype wire

// ==== source/gf_parallel_mult.sv ====
`timescale 1ns/1ps
`default_nettype none

// bit-parallel standard basis multiplier, p = a * b
module gf_parallel_mult #(
	parameter int M = 8,
	parameter logic [M-1:0] POLY = 8'h1d
) (
	input  logic [M-1:0] a,
	input  logic [M-1:0] b,
	output logic [M-1:0] p
);
	localparam int W = gf_pkg::GF_MAX_M;

	// ladder[i] = a * alpha^i
	logic [M-1:0][M-1:0] ladder;

	assign ladder[0] = a;

	for (genvar i = 1; i < M; i++) begin : g_ladder
		logic [W-1:0] step;

		assign step = gf_pkg::gf_mul_alpha(W'(ladder[i-1]), W'(POLY), M);
		assign ladder[i] = step[M-1:0];
	end

	// fold in one partial product per set bit of b
	always_comb begin
		p = '0;
		for (int i = 0; i < M; i++) begin
			if (b[i])
				p = p ^ ladder[i];
		end
	end
endmodule

`default_nettype wire

// ==== source/gf_power.sv ====
`timescale 1ns/1ps
`default_nettype none

// y = x^P in the standard basis for a fixed power P
module gf_power #(
	parameter int M = 8,
	parameter logic [M-1:0] POLY = 8'h1d,
	parameter int P = 2
) (
	input  logic [M-1:0] x,
	output logic [M-1:0] y
);
	localparam int W = gf_pkg::GF_MAX_M;

	// u * v with one alpha step of u per bit of v
	function automatic logic [M-1:0] mult(input logic [M-1:0] u, input logic [M-1:0] v);
		logic [W-1:0] s;
		logic [M-1:0] p;
		s = W'(u);
		p = '0;
		for (int i = 0; i < M; i++) begin
			if (v[i])
				p = p ^ s[M-1:0];
			s = gf_pkg::gf_mul_alpha(s, W'(POLY), M);
		end
		return p;
	endfunction

	// cubing is not linear over GF(2), so the power is a chain of P products
	always_comb begin
		y = M'(1);
		for (int k = 0; k < P; k++)
			y = mult(y, x);
	end
endmodule

`default_nettype wire

// ==== source/gf_execute.sv ====
`timescale 1ns/1ps
`default_nettype none

module gf_execute #(
	parameter int M = 8,
	parameter logic [M-1:0] POLY = 8'h1d
) (
	input  logic clk,
	input  logic reset,
	gf_cmd_if.dst cmd,
	gf_res_if.src res,
	output logic div_done
);
	localparam int CW = (M > 2) ? $clog2(M) : 1;
	// last loop index, M-2 iterations in total
	localparam logic [CW-1:0] LAST = CW'(M - 3);

	gf_pkg::gf_div_state_e state;
	logic [CW-1:0] iter;
	logic [M-1:0] t;
	logic [M-1:0] r;
	logic [M-1:0] a_hold;
	logic zero_hold;
	logic div_start;

	logic [M-1:0] sq_in;
	logic [M-1:0] sq_out;
	logic [M-1:0] cube_out;
	logic [M-1:0] mul_out;
	logic [M-1:0] acc_b;
	logic [M-1:0] acc_out;

	assign div_start = (state == gf_pkg::DIV_IDLE) && cmd.valid && (cmd.op == gf_pkg::OP_DIV);
	assign div_done = (state == gf_pkg::DIV_FINAL);

	// ********************
	// arithmetic units
	// ********************

	// squarer is shared, divisor on load, t while looping
	always_comb begin
		if (state != gf_pkg::DIV_IDLE)
			sq_in = t;
		else if (cmd.op == gf_pkg::OP_DIV)
			sq_in = cmd.b;
		else
			sq_in = cmd.a;
	end

	// accumulator takes a in the final step
	assign acc_b = (state == gf_pkg::DIV_FINAL) ? a_hold : sq_out;

	gf_power #(.M(M), .POLY(POLY), .P(2)) u_sqr (.x(sq_in), .y(sq_out));
	gf_power #(.M(M), .POLY(POLY), .P(3)) u_cube (.x(cmd.a), .y(cube_out));

	gf_parallel_mult #(.M(M), .POLY(POLY)) u_mul (.a(cmd.a), .b(cmd.b), .p(mul_out));
	gf_parallel_mult #(.M(M), .POLY(POLY)) u_acc (.a(r), .b(acc_b), .p(acc_out));

	// ********************
	// divide sequencer
	// ********************
	always_ff @(posedge clk) begin
		if (reset) begin
			state <= gf_pkg::DIV_IDLE;
			iter <= '0;
		end else begin
			case (state)
				gf_pkg::DIV_IDLE: begin
					iter <= '0;
					if (div_start)
						state <= gf_pkg::DIV_LOOP;
				end
				gf_pkg::DIV_LOOP: begin
					iter <= iter + 1'b1;
					if (iter == LAST)
						state <= gf_pkg::DIV_FINAL;
				end
				default: state <= gf_pkg::DIV_IDLE;
			endcase
		end
	end

	// t = b^(2^k), r = b^2 * b^4 * ... * b^(2^k)
	always_ff @(posedge clk) begin
		if (div_start) begin
			t <= sq_out;
			r <= sq_out;
			a_hold <= cmd.a;
			zero_hold <= cmd.div_zero;
		end else if (state == gf_pkg::DIV_LOOP) begin
			t <= sq_out;
			r <= acc_out;
		end
	end

	// result select
	always_comb begin
		res.valid = 1'b0;
		res.value = '0;
		res.div_zero = 1'b0;
		if (state == gf_pkg::DIV_FINAL) begin
			res.valid = 1'b1;
			res.value = zero_hold ? '0 : acc_out;
			res.div_zero = zero_hold;
		end else if (cmd.valid && cmd.op != gf_pkg::OP_DIV) begin
			res.valid = 1'b1;
			case (cmd.op)
				gf_pkg::OP_ADD:  res.value = cmd.a ^ cmd.b;
				gf_pkg::OP_MUL:  res.value = mul_out;
				gf_pkg::OP_SQR:  res.value = sq_out;
				gf_pkg::OP_CUBE: res.value = cube_out;
				default:         res.value = '0;
			endcase
		end
	end

	// decode must hold commands back for the whole divide
	a_cmd_when_idle: assert property (@(posedge clk) disable iff (reset)
		cmd.valid |-> state == gf_pkg::DIV_IDLE);

	a_quiet_after_reset: assert property (@(posedge clk)
		reset |=> !res.valid);
endmodule

`default_nettype wire

// ==== source/gf_result.sv ====
`timescale 1ns/1ps
`default_nettype none

// registered output stage
module gf_result #(
	parameter int M = 8
) (
	input  logic clk,
	input  logic reset,
	gf_res_if.dst res,
	output logic res_valid,
	output logic [M-1:0] res_value,
	output logic res_div_zero
);
	// ********************
	// valid strobe
	// ********************
	always_ff @(posedge clk) begin
		if (reset)
			res_valid <= 1'b0;
		else
			res_valid <= res.valid;
	end

	// value and flag hold between strobes
	always_ff @(posedge clk) begin
		if (res.valid) begin
			res_value <= res.value;
			res_div_zero <= res.div_zero;
		end
	end

	// the zero flag only ever comes with a zero value
	a_zero_value: assert property (@(posedge clk) disable iff (reset)
		res_valid && res_div_zero |-> res_value == '0);
endmodule

`default_nettype wire

// ==== source/gf_alu_top.sv ====
`timescale 1ns/1ps
`default_nettype none

// GF(2^M) arithmetic unit, decode -> execute -> result
module gf_alu_top #(
	parameter int M = 8,
	parameter logic [M-1:0] POLY = 8'h1d
) (
	input  logic clk,
	input  logic reset,
	input  logic cmd_valid,
	input  gf_pkg::gf_op_e cmd_op,
	input  logic [M-1:0] cmd_a,
	input  logic [M-1:0] cmd_b,
	output logic res_valid,
	output logic [M-1:0] res_value,
	output logic res_div_zero,
	output logic busy,
	output logic overrun
);
	logic div_done;

	gf_cmd_if #(.M(M)) cmd_bus ();
	gf_res_if #(.M(M)) res_bus ();

	gf_decode #(.M(M)) u_decode (
		.clk(clk),
		.reset(reset),
		.cmd_valid(cmd_valid),
		.cmd_op(cmd_op),
		.cmd_a(cmd_a),
		.cmd_b(cmd_b),
		.div_done(div_done),
		.busy(busy),
		.overrun(overrun),
		.cmd(cmd_bus.src)
	);

	gf_execute #(.M(M), .POLY(POLY)) u_execute (
		.clk(clk),
		.reset(reset),
		.cmd(cmd_bus.dst),
		.res(res_bus.src),
		.div_done(div_done)
	);

	gf_result #(.M(M)) u_result (
		.clk(clk),
		.reset(reset),
		.res(res_bus.dst),
		.res_valid(res_valid),
		.res_value(res_value),
		.res_div_zero(res_div_zero)
	);
endmodule

`default_nettype wire

// ==== tb/gf_alu_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

// scoreboard for the GF(2^M) unit that samples the DUT ports on the falling edge
module gf_alu_checker #(
	parameter int M = 8,
	parameter logic [M-1:0] POLY = 8'h1d
) (
	input  logic clk,
	input  logic reset,
	input  logic cmd_valid,
	input  gf_pkg::gf_op_e cmd_op,
	input  logic [M-1:0] cmd_a,
	input  logic [M-1:0] cmd_b,
	input  logic res_valid,
	input  logic [M-1:0] res_value,
	input  logic res_div_zero,
	input  logic busy,
	input  logic overrun,
	output int mismatch_count,
	output int other_count,
	output int pending
);
	// b^-1 = b^(2^M - 2)
	localparam int unsigned INV_EXP = (1 << M) - 2;

	// expected result and the cycle a simple op is due in
	typedef struct packed {
		gf_pkg::gf_op_e op;
		logic [M-1:0] value;
		logic div_zero;
		int due;
	} expect_t;

	expect_t expect_q[$];
	expect_t entry;
	int cycle = 0;
	logic overrun_due = 1'b0;
	logic seen_cmd = 1'b0;
	// a divide is running in the model
	logic busy_model = 1'b0;

	// ********************
	// reference model
	// ********************

	// shift-and-add multiply taking the msb of b first
	function automatic logic [M-1:0] ref_mul(input logic [M-1:0] a, input logic [M-1:0] b);
		logic [M-1:0] p;
		logic carry;
		p = '0;
		for (int i = M - 1; i >= 0; i--) begin
			carry = p[M-1];
			p = p << 1;
			if (carry)
				p = p ^ POLY;
			if (b[i])
				p = p ^ a;
		end
		return p;
	endfunction

	function automatic logic [M-1:0] ref_pow(input logic [M-1:0] x, input int unsigned e);
		logic [M-1:0] acc;
		acc = M'(1);
		for (int unsigned k = 0; k < e; k++)
			acc = ref_mul(acc, x);
		return acc;
	endfunction

	function automatic logic [M-1:0] ref_result(input gf_pkg::gf_op_e op,
		input logic [M-1:0] a, input logic [M-1:0] b);
		case (op)
			gf_pkg::OP_ADD:  return a ^ b;
			gf_pkg::OP_MUL:  return ref_mul(a, b);
			gf_pkg::OP_SQR:  return ref_pow(a, 2);
			gf_pkg::OP_CUBE: return ref_pow(a, 3);
			default:         return (b == '0) ? '0 : ref_mul(a, ref_pow(b, INV_EXP));
		endcase
	endfunction

	// ********************
	// comparison
	// ********************
	always @(negedge clk) begin
		if (reset) begin
			overrun_due = 1'b0;
			seen_cmd = 1'b0;
			busy_model = 1'b0;
		end else begin
			cycle++;
			// nothing moves before the first command
			if (!seen_cmd && (res_valid !== 1'b0 || busy !== 1'b0 || overrun !== 1'b0)) begin
				other_count++;
				$display("%0t: outputs active after reset before any command", $time);
			end
			if (overrun !== overrun_due) begin
				mismatch_count++;
				$display("Mismatch at %0t: overrun is %b, expected %b", $time, overrun, overrun_due);
			end
			if (res_valid === 1'b1 && expect_q.size() == 0) begin
				other_count++;
				$display("%0t: result %h arrived with no command outstanding", $time, res_value);
			end else if (res_valid === 1'b1) begin
				entry = expect_q.pop_front();
				if (res_value !== entry.value || res_div_zero !== entry.div_zero) begin
					mismatch_count++;
					$display("Mismatch at %0t: op %0d gave %h zero %b, expected %h zero %b",
						$time, entry.op, res_value, res_div_zero, entry.value, entry.div_zero);
				end
				if (entry.op != gf_pkg::OP_DIV && entry.due != cycle) begin
					other_count++;
					$display("%0t: op %0d result came in cycle %0d instead of %0d",
						$time, entry.op, cycle, entry.due);
				end
				// busy drops in the cycle of the divide result
				if (entry.op == gf_pkg::OP_DIV)
					busy_model = 1'b0;
			end
			if (busy !== busy_model) begin
				mismatch_count++;
				$display("Mismatch at %0t: busy is %b, expected %b", $time, busy, busy_model);
			end
			// a command during a divide is dropped and flagged in the next cycle
			overrun_due = (cmd_valid === 1'b1) && busy_model;
			if (cmd_valid === 1'b1 && !busy_model) begin
				entry.op = cmd_op;
				entry.value = ref_result(cmd_op, cmd_a, cmd_b);
				entry.div_zero = (cmd_op == gf_pkg::OP_DIV) && (cmd_b == '0);
				entry.due = (cmd_op == gf_pkg::OP_DIV) ? -1 : cycle + 2;
				expect_q.push_back(entry);
				// the quotient has to multiply back to the dividend
				if (cmd_op == gf_pkg::OP_DIV && !entry.div_zero
					&& ref_mul(entry.value, cmd_b) != cmd_a) begin
					other_count++;
					$display("%0t: model quotient %h times %h does not give %h",
						$time, entry.value, cmd_b, cmd_a);
				end
				if (cmd_op == gf_pkg::OP_DIV)
					busy_model = 1'b1;
			end
			seen_cmd = seen_cmd || (cmd_valid === 1'b1);
		end
		pending = expect_q.size();
	end
endmodule

`default_nettype wire

// ==== tb/gf_alu_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module gf_alu_tb;
	localparam int M = 8;
	localparam logic [M-1:0] POLY = 8'h1d;
	localparam logic [M-1:0] ALL_ONES = '1;
	localparam int CLK_PERIOD = 20;
	localparam int RESET_CYCLES = 16;
	// commands per phase
	localparam int N_CORNER = 64;
	localparam int N_RANDOM = 100;
	localparam int N_DIV = 30;
	localparam int N_ROUNDS = 2;
	localparam int TOTAL_CMDS = N_CORNER + N_RANDOM + N_DIV + 4 + N_ROUNDS * 8;
	localparam int WATCHDOG_CYCLES = TOTAL_CMDS * (M + 4) + RESET_CYCLES;

	logic clk = 1'b0;
	logic reset = 1'b1;
	logic cmd_valid = 1'b0;
	gf_pkg::gf_op_e cmd_op = gf_pkg::OP_ADD;
	logic [M-1:0] cmd_a = '0;
	logic [M-1:0] cmd_b = '0;
	logic res_valid;
	logic [M-1:0] res_value;
	logic res_div_zero;
	logic busy;
	logic overrun;
	int mismatch_count;
	int other_count;
	int pending;
	int leftover;
	logic [M-1:0] divisor;
	integer seed = 32'hfdc48237;

	always #(CLK_PERIOD / 2) clk = ~clk;

	gf_alu_top #(.M(M), .POLY(POLY)) i_gf_alu_top (.*);

	gf_alu_checker #(.M(M), .POLY(POLY)) u_checker (.*);

	function automatic logic [M-1:0] rand_elem();
		integer r;
		r = $random(seed);
		return r[M-1:0];
	endfunction

	// operand 0, 1, all ones, or random
	function automatic logic [M-1:0] corner_elem(input int idx);
		case (idx)
			0: return '0;
			1: return M'(1);
			2: return ALL_ONES;
			default: return rand_elem();
		endcase
	endfunction

	function automatic gf_pkg::gf_op_e rand_simple_op();
		integer r;
		r = $random(seed);
		return gf_pkg::gf_op_e'({1'b0, r[1:0]});
	endfunction

	task automatic send_cmd(input gf_pkg::gf_op_e op, input logic [M-1:0] a,
		input logic [M-1:0] b);
		cmd_valid <= 1'b1;
		cmd_op <= op;
		cmd_a <= a;
		cmd_b <= b;
		@(posedge clk);
	endtask

	// release the command bus and let a divide run out
	task automatic wait_not_busy();
		cmd_valid <= 1'b0;
		@(negedge clk);
		while (busy)
			@(negedge clk);
		@(posedge clk);
	endtask

	// ********************
	// stimulus
	// ********************
	initial begin
		repeat (RESET_CYCLES) @(posedge clk);
		reset <= 1'b0;
		// quiet window before the first command
		repeat (8) @(posedge clk);
		for (int op = 0; op < 4; op++)
			for (int i = 0; i < 4; i++)
				for (int j = 0; j < 4; j++)
					send_cmd(gf_pkg::gf_op_e'(op[2:0]), corner_elem(i), corner_elem(j));
		for (int n = 0; n < N_RANDOM; n++)
			send_cmd(rand_simple_op(), rand_elem(), rand_elem());
		wait_not_busy();
		for (int n = 0; n < N_DIV; n++) begin
			divisor = rand_elem();
			if (divisor == '0)
				divisor = M'(1);
			send_cmd(gf_pkg::OP_DIV, rand_elem(), divisor);
			wait_not_busy();
		end
		// zero divisor
		for (int i = 0; i < 4; i++) begin
			send_cmd(gf_pkg::OP_DIV, corner_elem(i), '0);
			wait_not_busy();
		end
		// three commands dropped behind each divide
		for (int n = 0; n < N_ROUNDS; n++) begin
			send_cmd(gf_pkg::OP_DIV, rand_elem(), ALL_ONES);
			send_cmd(rand_simple_op(), rand_elem(), rand_elem());
			send_cmd(gf_pkg::OP_MUL, rand_elem(), rand_elem());
			send_cmd(gf_pkg::OP_DIV, rand_elem(), rand_elem());
			wait_not_busy();
			for (int i = 0; i < 4; i++)
				send_cmd(rand_simple_op(), rand_elem(), rand_elem());
			wait_not_busy();
		end
		for (int i = 0; i < 2 * (M + 4) && pending != 0; i++)
			@(posedge clk);
		repeat (4) @(posedge clk);
		leftover = pending;
		if (leftover != 0)
			$display("%0d expected results never arrived", leftover);
		$display("error counts: %0d mismatches, %0d other errors, %0d missing results",
			mismatch_count, other_count, leftover);
		if (mismatch_count + other_count + leftover == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

	// watchdog
	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("ERRORS FOUND");
		$finish;
	end
endmodule

`default_nettype wire

// ==== src.f ====
source/gf_pkg.sv
source/gf_cmd_if.sv
source/gf_res_if.sv
source/gf_decode.sv
source/gf_parallel_mult.sv
source/gf_power.sv
source/gf_execute.sv
source/gf_result.sv
source/gf_alu_top.sv
tb/gf_alu_checker.sv
tb/gf_alu_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS ?= --binary --timing --assert -Wno-fatal
TOP ?= gf_alu_tb
FILELIST ?= src.f

OBJ_DIR := obj_dir
SIM_BIN := $(OBJ_DIR)/V$(TOP)
LOG := sim.log
SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	grep -q '^NO ERRORS$$' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
